//--- common/gui_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// raster constants are for 640x480 at 60 Hz with a 25 MHz class pixel clock
// tiles are 32x16 pixels, so the index is {y[9:4], x[9:5]}
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package gui_pkg;

    typedef logic [9:0]  coord_t;      // beam or pointer coordinate
    typedef logic [8:0]  color_t;      // rgb 3:3:3
    typedef logic [10:0] tile_addr_t;  // row (6 bits) then column (5 bits)

    localparam coord_t h_visible = 10'd640;
    localparam coord_t h_front   = 10'd16;
    localparam coord_t h_sync    = 10'd96;
    localparam coord_t h_back    = 10'd48;
    localparam coord_t h_total   = h_visible + h_front + h_sync + h_back;  // 800

    localparam coord_t v_visible = 10'd480;
    localparam coord_t v_front   = 10'd10;
    localparam coord_t v_sync    = 10'd2;
    localparam coord_t v_back    = 10'd33;
    localparam coord_t v_total   = v_visible + v_front + v_sync + v_back;  // 525

    localparam coord_t pointer_reset_x = 10'd320;
    localparam coord_t pointer_reset_y = 10'd240;

    localparam color_t crosshair_color   = 9'h1FF;
    localparam color_t first_paint_color = 9'h049;
    localparam color_t paint_color_step  = 9'h035;  // wraps modulo 512

    typedef enum logic [1:0] {idle, data, parity, stop} ps2_state_e;
    typedef enum logic {wait_req, ack_high} hs_state_e;

    // tile under a screen coordinate
    function automatic tile_addr_t tile_index(input coord_t x, input coord_t y);
        return {y[9:4], x[9:5]};
    endfunction

endpackage

`default_nettype wire

//--- hw/mouse/ps2_mouse_rx.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// receive only; the mouse must already be in stream mode
// ps2_filter_len must be at least 2; packets finishing during a handshake are dropped
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module ps2_mouse_rx #(
    parameter int ps2_filter_len = 4
) (
    input  wire logic       clk_pixel,
    input  wire logic       arst_n,
    input  wire logic       ps2_clk,
    input  wire logic       ps2_dat,
    input  wire logic       pkt_ack,
    output logic            pkt_req,
    output logic [7:0]      pkt_status,
    output logic [7:0]      pkt_dx,
    output logic [7:0]      pkt_dy
);
    import gui_pkg::*;

    logic clk_s1, clk_s2, dat_s1, dat_s2;
    logic [ps2_filter_len-2:0] clk_hist;
    logic [ps2_filter_len-1:0] clk_win;    // newest sample in bit 0
    logic clk_filt, clk_fall, clk_edge;
    logic [11:0] gap_cnt;
    logic timeout, byte_done, pkt_load, busy;
    ps2_state_e state;
    logic [2:0] bit_cnt;
    logic par_ok;
    logic [1:0] byte_cnt;                  // good bytes of the packet so far
    logic [7:0] shreg, byte0_q, byte1_q;

    assign clk_win  = {clk_hist, clk_s2};
    assign clk_fall = clk_filt && (clk_win == '0);
    assign clk_edge = clk_fall || (!clk_filt && (&clk_win));
    assign busy     = pkt_req || pkt_ack;  // handshake not back to rest
    assign timeout  = gap_cnt[11] && (state != idle || byte_cnt != 2'd0);

    // stop bit sampled and byte is good
    assign byte_done = clk_fall && !timeout && state == stop && dat_s2 && par_ok;
    assign pkt_load  = byte_done && byte_cnt == 2'd2 && !busy;

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            {clk_s1, clk_s2, dat_s1, dat_s2} <= '1;   // idle bus is high
            clk_hist <= '1;
            clk_filt <= 1'b1;
            gap_cnt  <= '0;
        end
        else
        begin
            clk_s1 <= ps2_clk;
            clk_s2 <= clk_s1;
            dat_s1 <= ps2_dat;
            dat_s2 <= dat_s1;
            clk_hist <= clk_win[ps2_filter_len-2:0];
            if (clk_edge)
                clk_filt <= !clk_filt;
            if (clk_edge)
                gap_cnt <= '0;
            else if (!gap_cnt[11])
                gap_cnt <= gap_cnt + 12'd1;  // saturates at 2048
        end
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= idle;
            bit_cnt  <= '0;
            par_ok   <= 1'b0;
            byte_cnt <= '0;
            pkt_req  <= 1'b0;
        end
        else
        begin
            if (timeout)
            begin
                state    <= idle;            // drop the partial packet
                byte_cnt <= '0;
            end
            else if (clk_fall)
            begin
                case (state)
                    idle:
                        if (!dat_s2)
                        begin
                            state   <= data;
                            bit_cnt <= '0;
                        end
                    data:
                    begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= parity;
                    end
                    parity:
                    begin
                        par_ok <= ^{shreg, dat_s2};  // odd parity
                        state  <= stop;
                    end
                    stop:
                    begin
                        state <= idle;
                        if (!byte_done || byte_cnt == 2'd2)
                            byte_cnt <= '0;
                        else if (byte_cnt != 2'd0 || shreg[3])
                            byte_cnt <= byte_cnt + 2'd1;  // byte 0 needs bit 3 set
                    end
                    default: state <= idle;
                endcase
            end

            if (pkt_load)
                pkt_req <= 1'b1;
            else if (pkt_ack)
                pkt_req <= 1'b0;
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (clk_fall && state == data)
            shreg <= {dat_s2, shreg[7:1]};   // lsb first
        if (byte_done && byte_cnt == 2'd0)
            byte0_q <= shreg;
        if (byte_done && byte_cnt == 2'd1)
            byte1_q <= shreg;
        if (pkt_load)
        begin
            pkt_status <= byte0_q;
            pkt_dx     <= byte1_q;
            pkt_dy     <= shreg;
        end
    end

    a_pkt_stable: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        pkt_req && $past(pkt_req) |-> $stable({pkt_status, pkt_dx, pkt_dy}))
        else $error("packet changed while pkt_req high");

    a_req_hold: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        $fell(pkt_req) |-> $past(pkt_ack))
        else $error("pkt_req dropped before pkt_ack");

endmodule

`default_nettype wire

//--- hw/mouse/mouse_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pointer is clamped to the visible 640x480 area, overflow bits are ignored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module mouse_tracker (
    input  wire logic       clk_pixel,
    input  wire logic       arst_n,
    input  wire logic       pkt_req,
    input  wire logic [7:0] pkt_status,
    input  wire logic [7:0] pkt_dx,
    input  wire logic [7:0] pkt_dy,
    output logic            pkt_ack,
    output gui_pkg::coord_t mouse_x,
    output gui_pkg::coord_t mouse_y,
    output logic [2:0]      mouse_btn
);
    import gui_pkg::*;

    hs_state_e hs_state;
    logic apply_q;                 // latched packet waits to be applied
    logic [8:0] dx_q, dy_q;        // 9-bit two's complement deltas
    logic [2:0] btn_q;
    logic signed [11:0] x_sum, y_sum;

    function automatic coord_t clamp_coord(input logic signed [11:0] v, input coord_t hi);
        coord_t r;
        if (v < 0)
            r = '0;
        else if (v > $signed({2'b00, hi}))
            r = hi;
        else
            r = v[9:0];
        return r;
    endfunction

    assign x_sum = $signed({2'b00, mouse_x}) + $signed({{3{dx_q[8]}}, dx_q});
    assign y_sum = $signed({2'b00, mouse_y}) - $signed({{3{dy_q[8]}}, dy_q});  // ps2 y is up

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hs_state  <= wait_req;
            pkt_ack   <= 1'b0;
            apply_q   <= 1'b0;
            mouse_x   <= pointer_reset_x;
            mouse_y   <= pointer_reset_y;
            mouse_btn <= '0;
        end
        else
        begin
            apply_q <= 1'b0;
            case (hs_state)
                wait_req:
                    if (pkt_req)
                    begin
                        pkt_ack  <= 1'b1;
                        apply_q  <= 1'b1;
                        hs_state <= ack_high;
                    end
                ack_high:
                    if (!pkt_req)
                    begin
                        pkt_ack  <= 1'b0;
                        hs_state <= wait_req;
                    end
                default: hs_state <= wait_req;
            endcase

            if (apply_q)
            begin
                mouse_x   <= clamp_coord(x_sum, h_visible - 10'd1);
                mouse_y   <= clamp_coord(y_sum, v_visible - 10'd1);
                mouse_btn <= btn_q;
            end
        end
    end

    always_ff @(posedge clk_pixel)
    begin
        if (hs_state == wait_req && pkt_req)
        begin
            dx_q  <= {pkt_status[4], pkt_dx};
            dy_q  <= {pkt_status[5], pkt_dy};
            btn_q <= pkt_status[2:0];   // left, right, middle
        end
    end

    a_x_visible: assert property (@(posedge clk_pixel) disable iff (!arst_n)
        mouse_x < h_visible)
        else $error("mouse_x left the visible area");

endmodule

`default_nettype wire

//--- hw/video_timing.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 640x480 at 60 Hz, active-low syncs, decodes are combinational from the counters
// starts on the last line after reset, so the first full frame follows one line later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module video_timing (
    input  wire logic       clk_pixel,
    input  wire logic       arst_n,
    output gui_pkg::coord_t beam_x,
    output gui_pkg::coord_t beam_y,
    output logic            hsync,
    output logic            vsync,
    output logic            blank
);
    import gui_pkg::*;

    localparam coord_t hs_start = h_visible + h_front;   // 656
    localparam coord_t hs_end   = hs_start + h_sync;      // 752
    localparam coord_t vs_start = v_visible + v_front;    // 490
    localparam coord_t vs_end   = vs_start + v_sync;      // 492

    logic line_end, frame_end;

    assign line_end  = (beam_x == h_total - 10'd1);
    assign frame_end = (beam_y == v_total - 10'd1);

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            beam_x <= '0;
            beam_y <= v_total - 10'd1;   // inside vertical blank
        end
        else
        begin
            if (line_end)
            begin
                beam_x <= '0;
                if (frame_end)
                    beam_y <= '0;
                else
                    beam_y <= beam_y + 10'd1;
            end
            else
            begin
                beam_x <= beam_x + 10'd1;
            end
        end
    end

    // sync pulses sit between front and back porch
    assign hsync = !(beam_x >= hs_start && beam_x < hs_end);
    assign vsync = !(beam_y >= vs_start && beam_y < vs_end);
    assign blank = (beam_x >= h_visible) || (beam_y >= v_visible);

endmodule

`default_nettype wire

//--- hw/tile_canvas.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two cycle pixel latency, beam and syncs come out delayed to match
// tiles paint every cycle a button is held; the crosshair uses the current pointer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tile_canvas (
    input  wire logic            clk_pixel,
    input  wire logic            arst_n,
    input  wire gui_pkg::coord_t beam_x,
    input  wire gui_pkg::coord_t beam_y,
    input  wire logic            hsync_raw,
    input  wire logic            vsync_raw,
    input  wire logic            blank_raw,
    input  wire gui_pkg::coord_t mouse_x,
    input  wire gui_pkg::coord_t mouse_y,
    input  wire logic [2:0]      mouse_btn,
    output gui_pkg::coord_t      beam_x_out,
    output gui_pkg::coord_t      beam_y_out,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 blank,
    output gui_pkg::color_t      pixel_color
);
    import gui_pkg::*;

    color_t tile_ram [0:2047];
    color_t tile_q;                // stage 1 read data
    color_t paint_color;
    logic left_q;                  // left button one cycle ago
    tile_addr_t rd_addr, wr_addr;
    coord_t x_s1, y_s1;
    logic hsync_s1, vsync_s1, blank_s1;

    initial tile_ram = '{default: '0};   // canvas starts black

    assign rd_addr = tile_index(beam_x, beam_y);
    assign wr_addr = tile_index(mouse_x, mouse_y);

    // write port follows the pointer, left wins over right
    always_ff @(posedge clk_pixel)
    begin
        if (mouse_btn[0])
            tile_ram[wr_addr] <= paint_color;
        else if (mouse_btn[1])
            tile_ram[wr_addr] <= '0;
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            paint_color <= first_paint_color;
            left_q      <= 1'b0;
        end
        else
        begin
            left_q <= mouse_btn[0];
            if (left_q && !mouse_btn[0])
                paint_color <= paint_color + paint_color_step;  // on release
        end
    end

    // pixel path, stage 1 reads the ram and stage 2 overlays
    always_ff @(posedge clk_pixel)
    begin
        tile_q     <= tile_ram[rd_addr];
        x_s1       <= beam_x;
        y_s1       <= beam_y;
        beam_x_out <= x_s1;
        beam_y_out <= y_s1;
        if (blank_s1)
            pixel_color <= '0;
        else if (x_s1 == mouse_x || y_s1 == mouse_y)
            pixel_color <= crosshair_color;
        else
            pixel_color <= tile_q;
    end

    always_ff @(posedge clk_pixel or negedge arst_n)
    begin
        if (!arst_n)
        begin
            {hsync_s1, vsync_s1, blank_s1} <= 3'b111;
            {hsync, vsync, blank}          <= 3'b111;   // syncs inactive, blanked
        end
        else
        begin
            {hsync_s1, vsync_s1, blank_s1} <= {hsync_raw, vsync_raw, blank_raw};
            {hsync, vsync, blank}          <= {hsync_s1, vsync_s1, blank_s1};
        end
    end

endmodule

`default_nettype wire

//--- hw/mouse_gui_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// all on clk_pixel; ps2 lines are input only, parallel rgb out without serializer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module mouse_gui_top #(
    parameter int ps2_filter_len = 4
) (
    input  wire logic       clk_pixel,
    input  wire logic       arst_n,
    input  wire logic       ps2_clk,
    input  wire logic       ps2_dat,
    output gui_pkg::coord_t beam_x,
    output gui_pkg::coord_t beam_y,
    output logic            hsync,
    output logic            vsync,
    output logic            blank,
    output gui_pkg::color_t pixel_color,
    output gui_pkg::coord_t mouse_x,
    output gui_pkg::coord_t mouse_y,
    output logic [2:0]      mouse_btn
);
    import gui_pkg::*;

    logic pkt_req, pkt_ack;
    logic [7:0] pkt_status, pkt_dx, pkt_dy;
    coord_t beam_x_raw, beam_y_raw;     // undelayed beam
    logic hsync_raw, vsync_raw, blank_raw;

    ps2_mouse_rx #(.ps2_filter_len(ps2_filter_len)) u_rx (
        .clk_pixel(clk_pixel), .arst_n(arst_n), .ps2_clk(ps2_clk), .ps2_dat(ps2_dat),
        .pkt_ack(pkt_ack), .pkt_req(pkt_req), .pkt_status(pkt_status),
        .pkt_dx(pkt_dx), .pkt_dy(pkt_dy));

    mouse_tracker u_tracker (
        .clk_pixel(clk_pixel), .arst_n(arst_n), .pkt_req(pkt_req),
        .pkt_status(pkt_status), .pkt_dx(pkt_dx), .pkt_dy(pkt_dy), .pkt_ack(pkt_ack),
        .mouse_x(mouse_x), .mouse_y(mouse_y), .mouse_btn(mouse_btn));

    video_timing u_timing (
        .clk_pixel(clk_pixel), .arst_n(arst_n), .beam_x(beam_x_raw), .beam_y(beam_y_raw),
        .hsync(hsync_raw), .vsync(vsync_raw), .blank(blank_raw));

    tile_canvas u_canvas (
        .clk_pixel(clk_pixel), .arst_n(arst_n), .beam_x(beam_x_raw), .beam_y(beam_y_raw),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .blank_raw(blank_raw),
        .mouse_x(mouse_x), .mouse_y(mouse_y), .mouse_btn(mouse_btn),
        .beam_x_out(beam_x), .beam_y_out(beam_y), .hsync(hsync), .vsync(vsync),
        .blank(blank), .pixel_color(pixel_color));

endmodule

`default_nettype wire

//--- dv/ps2_device_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// device to host direction only, half period of 40 clk_pixel cycles
// drives ps2_clk and ps2_dat of the including module on rising clk_pixel edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ps2_device_model_svh
`define ps2_device_model_svh

localparam int ps2_half_period = 40;
localparam int ps2_byte_gap    = 60;   // idle cycles before each start bit

task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_pixel);
endtask

// data changes while the clock is high, host samples on the falling edge
task automatic drive_bit(input logic b);
    ps2_dat <= b;
    wait_cycles(ps2_half_period);
    ps2_clk <= 1'b0;
    wait_cycles(ps2_half_period);
    ps2_clk <= 1'b1;
endtask

// start, 8 data bits lsb first, odd parity, stop
task automatic send_byte(input logic [7:0] value, input logic bad_parity);
    logic par_bit;
    par_bit = ~^value ^ bad_parity;
    wait_cycles(ps2_byte_gap);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++)
        drive_bit(value[i]);
    drive_bit(par_bit);
    drive_bit(1'b1);             // leaves the bus idle high
endtask

// bad_byte picks the byte sent with wrong parity, -1 for none
task automatic send_packet(input logic [7:0] b0, input logic [7:0] b1,
                           input logic [7:0] b2, input int bad_byte);
    send_byte(b0, bad_byte == 0);
    send_byte(b1, bad_byte == 1);
    send_byte(b2, bad_byte == 2);
endtask

`endif

//--- dv/tb_mouse_gui.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random ps2 packets against a pointer and canvas model with frames checked per pixel
// needs timing support in the simulator; the lfsr seed is a top level parameter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_mouse_gui #(
    parameter logic [31:0] seed = 32'haeee_eb44
);
    import gui_pkg::*;

    logic clk_pixel = 1'b0;
    logic arst_n    = 1'b0;
    logic ps2_clk   = 1'b1;    // idle bus
    logic ps2_dat   = 1'b1;

    coord_t beam_x, beam_y, mouse_x, mouse_y;
    logic hsync, vsync, blank;
    color_t pixel_color;
    logic [2:0] mouse_btn;

    // reference model of pointer, buttons and canvas
    int model_x;
    int model_y;
    logic [2:0] model_btn;
    color_t model_paint;
    color_t model_tile [0:2047];

    logic [31:0] lfsr_state;
    int error_count;
    int check_count;

    `include "ps2_device_model.svh"

    mouse_gui_top #(
        .ps2_filter_len(4)
    ) UUT (
        .clk_pixel(clk_pixel),
        .arst_n(arst_n),
        .ps2_clk(ps2_clk),
        .ps2_dat(ps2_dat),
        .beam_x(beam_x),
        .beam_y(beam_y),
        .hsync(hsync),
        .vsync(vsync),
        .blank(blank),
        .pixel_color(pixel_color),
        .mouse_x(mouse_x),
        .mouse_y(mouse_y),
        .mouse_btn(mouse_btn)
    );

    always #10 clk_pixel = !clk_pixel;   // 20 ns period

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            error_count++;
            $display("[ERROR] %s: expected 'h%0h, actual 'h%0h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    endtask

    // pointer, buttons and canvas after one accepted packet
    task automatic apply_packet(input logic [7:0] status, input logic [7:0] dx,
                                input logic [7:0] dy);
        int dxs;
        int dys;
        int idx;
        logic was_left;
        dxs = status[4] ? int'(dx) - 256 : int'(dx);
        dys = status[5] ? int'(dy) - 256 : int'(dy);
        model_x = model_x + dxs;
        model_y = model_y - dys;             // ps2 y points up
        if (model_x < 0)
            model_x = 0;
        if (model_x > int'(h_visible) - 1)
            model_x = int'(h_visible) - 1;
        if (model_y < 0)
            model_y = 0;
        if (model_y > int'(v_visible) - 1)
            model_y = int'(v_visible) - 1;
        was_left  = model_btn[0];
        model_btn = status[2:0];
        idx = (model_y / 16) * 32 + model_x / 32;
        if (model_btn[0])
            model_tile[idx] = model_paint;
        else if (model_btn[1])
            model_tile[idx] = '0;
        if (was_left && !model_btn[0])
            model_paint = model_paint + paint_color_step;   // advances on release
    endtask

    // tracker is updated within 10 cycles of the last ps2 clock edge
    task automatic settle();
        repeat (10) @(posedge clk_pixel);
        @(negedge clk_pixel);
    endtask

    task automatic move_and_check(input string name, input logic [2:0] btn,
                                  input logic [8:0] dx9, input logic [8:0] dy9);
        logic [7:0] status;
        status = {2'b00, dy9[8], dx9[8], 1'b1, btn};
        send_packet(status, dx9[7:0], dy9[7:0], -1);
        settle();
        apply_packet(status, dx9[7:0], dy9[7:0]);
        check_value({name, " x"}, model_x, 32'(mouse_x));
        check_value({name, " y"}, model_y, 32'(mouse_y));
        check_value({name, " btn"}, 32'(model_btn), 32'(mouse_btn));
    endtask

    task automatic move_to(input string name, input int tx, input int ty);
        int step_x;
        int step_y;
        int tries;
        tries = 0;
        while (model_x != tx || model_y != ty)
        begin
            step_x = tx - model_x;
            step_y = model_y - ty;
            step_x = step_x > 255 ? 255 : (step_x < -255 ? -255 : step_x);
            step_y = step_y > 255 ? 255 : (step_y < -255 ? -255 : step_y);
            move_and_check(name, 3'b000, 9'(step_x), 9'(step_y));
            tries++;
            if (tries > 8)
            begin
                $display("pointer did not reach (%0d,%0d) in %s", tx, ty, name);
                error_count++;
                finish_run();
            end
        end
    endtask

    // one full frame from (0,0) with beam position, sync widths, blank and every pixel
    task automatic scan_frame(input string name);
        int waited;
        int bx;
        int by;
        int hs_low;
        int vs_low;
        int hs_pulses;
        int vs_pulses;
        logic exp_blank;
        color_t exp_color;
        waited = 0;
        @(negedge clk_pixel);
        while (int'(beam_x) != 0 || int'(beam_y) != 0)
        begin
            waited++;
            if (waited > 800 * 525 + 10)
            begin
                $display("frame start never seen in %s", name);
                error_count++;
                finish_run();
            end
            @(negedge clk_pixel);
        end
        hs_low    = 0;
        vs_low    = 0;
        hs_pulses = 0;
        vs_pulses = 0;
        for (int n = 0; n < 800 * 525; n++)
        begin
            bx = n % 800;                // model beam position
            by = n / 800;
            exp_blank = (bx >= int'(h_visible)) || (by >= int'(v_visible));
            if (exp_blank)
                exp_color = '0;
            else if (bx == model_x || by == model_y)
                exp_color = crosshair_color;
            else
                exp_color = model_tile[(by / 16) * 32 + bx / 32];
            check_value({name, " beam_x"}, bx, 32'(beam_x));
            check_value({name, " beam_y"}, by, 32'(beam_y));
            check_value({name, " blank"}, 32'(exp_blank), 32'(blank));
            check_value({name, " pixel"}, 32'(exp_color), 32'(pixel_color));
            if (!hsync)
                hs_low++;
            else if (hs_low != 0)
            begin
                check_value({name, " hsync width"}, 96, hs_low);
                hs_pulses++;
                hs_low = 0;
            end
            if (!vsync)
                vs_low++;
            else if (vs_low != 0)
            begin
                check_value({name, " vsync width"}, 2 * 800, vs_low);   // two lines
                vs_pulses++;
                vs_low = 0;
            end
            @(negedge clk_pixel);
        end
        check_value({name, " hsync pulses"}, 525, hs_pulses);
        check_value({name, " vsync pulses"}, 1, vs_pulses);
    endtask

    initial
    begin
        logic [8:0] dx9;
        logic [8:0] dy9;
        logic [7:0] dx;
        logic [7:0] dy;
        int tx;
        int ty;
        int first_x;
        int first_y;

        lfsr_state  = seed;
        error_count = 0;
        check_count = 0;
        model_x     = 320;
        model_y     = 240;
        model_btn   = '0;
        model_paint = first_paint_color;
        for (int i = 0; i < 2048; i++)
            model_tile[i] = '0;

        repeat (5) @(posedge clk_pixel);
        arst_n <= 1'b1;
        @(negedge clk_pixel);
        check_value("reset mouse_x", 320, 32'(mouse_x));
        check_value("reset mouse_y", 240, 32'(mouse_y));
        check_value("reset mouse_btn", 0, 32'(mouse_btn));
        check_value("reset blank", 1, 32'(blank));
        check_value("reset hsync", 1, 32'(hsync));
        check_value("reset vsync", 1, 32'(vsync));

        // first ten moves push the pointer into all four edges
        for (int i = 0; i < 40; i++)
        begin
            dx9 = 9'(take_bits(9));
            dy9 = 9'(take_bits(9));
            if (i < 3)
                dx9 = 9'h101;            // -255
            else if (i < 6)
                dx9 = 9'h0ff;
            else if (i < 8)
                dy9 = 9'h0ff;            // up
            else if (i < 10)
                dy9 = 9'h101;
            move_and_check("random move", 3'b000, dx9, dy9);
        end

        // bit 3 clear so leftover bytes cannot start a packet
        dx = 8'(take_bits(8)) & 8'hf7;
        dy = 8'(take_bits(8)) & 8'hf7;
        send_packet(8'h08, dx, dy, 1);
        settle();
        check_value("bad parity x", model_x, 32'(mouse_x));
        check_value("bad parity y", model_y, 32'(mouse_y));
        send_packet(8'h00, dx, dy, -1);
        settle();
        check_value("no sync bit x", model_x, 32'(mouse_x));
        check_value("no sync bit y", model_y, 32'(mouse_y));
        dx9 = 9'(take_bits(9));
        dy9 = 9'(take_bits(9));
        move_and_check("after errors", 3'b000, dx9, dy9);

        scan_frame("blank canvas");

        for (int r = 0; r < 3; r++)
        begin
            tx = int'(take_bits(10)) % 640;
            ty = int'(take_bits(9)) % 480;
            if (r == 0)
            begin
                first_x = tx;
                first_y = ty;
            end
            move_to("paint move", tx, ty);
            move_and_check("left press", 3'b001, 9'd0, 9'd0);
            move_and_check("left release", 3'b000, 9'd0, 9'd0);
        end
        move_to("erase move", first_x, first_y);
        move_and_check("right press", 3'b010, 9'd0, 9'd0);
        move_and_check("right release", 3'b000, 9'd0, 9'd0);

        scan_frame("painted canvas");
        finish_run();
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+dv
common/gui_pkg.sv
hw/mouse/ps2_mouse_rx.sv
hw/mouse/mouse_tracker.sv
hw/video_timing.sv
hw/tile_canvas.sv
hw/mouse_gui_top.sv
dv/tb_mouse_gui.sv

//--- Makefile
# Verilator build and run of the mouse and tile canvas testbench
VERILATOR ?= verilator
TOP       ?= tb_mouse_gui
LOG       ?= sim.log
SEED      ?= aeeeeb44
OBJ_DIR   ?= obj_dir_$(SEED)

SOURCES := $(shell grep -v '^+' all.f)
HEADERS := $(wildcard dv/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# rebuilt only when a source, a header or the file list changes
$(BIN): all.f $(SOURCES) $(HEADERS)
	$(VERILATOR) --binary --timing --assert -f all.f --top-module $(TOP) \
		-Gseed=32\'h$(SEED) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || echo "Errors found" >> $(LOG)
	@cat $(LOG)

check: run
	@if grep -q "Errors found" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf obj_dir_* $(LOG)
